//--- logic/mem_pkg.sv
package mem_pkg;

    // width of one load, store or fetch
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        DREAD  = 3'd1,
        DWRITE = 3'd2,
        IOWAIT = 3'd3,
        FETCH  = 3'd4,
        DONE   = 3'd5
    } ctrl_state_e;

    // console output is never cached
    localparam logic [31:0] CONSOLE_ADDR0 = 32'h0003_0000;
    localparam logic [31:0] CONSOLE_ADDR1 = 32'h0003_0004;

    function automatic logic [2:0] size_bytes(access_size_e size);
        case (size)
            SIZE_BYTE: return 3'd1;
            SIZE_HALF: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

    function automatic logic is_console(logic [31:0] addr);
        return (addr == CONSOLE_ADDR0) || (addr == CONSOLE_ADDR1);
    endfunction

    // little endian byte pick
    function automatic logic [7:0] get_byte(logic [31:0] word, logic [1:0] idx);
        return word[{idx, 3'b000} +: 8];
    endfunction

endpackage

//--- logic/cache_port_if.sv
`timescale 1ns/1ns

interface cache_port_if #(
    parameter int INDEX_LEN = 6
);

    // word address without the byte offset
    logic [29:0]          lookup_addr;
    logic [INDEX_LEN-1:0] index;
    logic [29-INDEX_LEN:0] tag;
    logic                 hit;
    logic [31:0]          rdata;
    logic                 fill_en;
    logic [31:0]          fill_data;
    logic                 inval_en;

    assign index = lookup_addr[INDEX_LEN-1:0];
    assign tag   = lookup_addr[29:INDEX_LEN];

    modport fsm (
        output lookup_addr, fill_en, fill_data, inval_en,
        input  hit, rdata
    );

    modport cache (
        input  index, tag, fill_en, fill_data, inval_en,
        output hit, rdata
    );

endinterface

//--- logic/direct_cache.sv
`timescale 1ns/1ns

module direct_cache #(
    parameter int INDEX_LEN = 6
) (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         rdy_in,
    cache_port_if.cache  cache
);

    localparam int ENTRIES = 1 << INDEX_LEN;
    localparam int TAG_LEN = 30 - INDEX_LEN;

    logic [31:0]        data_mem [ENTRIES];
    logic [TAG_LEN-1:0] tag_mem  [ENTRIES];
    logic [ENTRIES-1:0] valid;

    // combinational lookup
    assign cache.hit   = valid[cache.index] && (tag_mem[cache.index] == cache.tag);
    assign cache.rdata = data_mem[cache.index];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid <= '0;
        end else if (rdy_in) begin
            if (cache.fill_en) begin
                valid[cache.index] <= 1'b1;
            end else if (cache.inval_en) begin
                valid[cache.index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && cache.fill_en) begin
            data_mem[cache.index] <= cache.fill_data;
            tag_mem[cache.index]  <= cache.tag;
        end
    end

    // the fsm never refreshes and drops an entry at once
    assert property (@(posedge clk_in) disable iff (rst_in)
        !(cache.fill_en && cache.inval_en));

endmodule

//--- logic/byte_counter.sv
`timescale 1ns/1ns

module byte_counter (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  rdy_in,
    input  logic                  start,
    input  logic                  step,
    input  mem_pkg::access_size_e size,
    output logic [2:0]            count,
    output logic                  last
);

    // count sits on the final byte of the access
    assign last = (count == (mem_pkg::size_bytes(size) - 3'd1));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count <= 3'd0;
        end else if (rdy_in) begin
            if (start) begin
                count <= 3'd0;
            end else if (step) begin
                count <= count + 3'd1;
            end
        end
    end

    // reads run one past the last byte, so 4 is the ceiling
    assert property (@(posedge clk_in) disable iff (rst_in) count <= 3'd4);

endmodule

//--- logic/byte_lanes.sv
`timescale 1ns/1ns

module byte_lanes (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic        rdy_in,
    input  logic        capture,
    input  logic [2:0]  count,
    input  logic [7:0]  ram_d_in,
    input  logic [31:0] wdata,
    output logic [31:0] word_out,
    output logic [7:0]  byte_out
);

    logic [31:0] word_q;
    logic [31:0] merged;
    logic [1:0]  slot;

    // data trails the address by one cycle
    assign slot = count[1:0] - 2'd1;

    always_comb begin
        merged = word_q;
        merged[{slot, 3'b000} +: 8] = ram_d_in;
    end

    // the last byte shows up here in its capture cycle
    assign word_out = capture ? merged : word_q;

    assign byte_out = mem_pkg::get_byte(wdata, count[1:0]);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            word_q <= '0;
        end else if (rdy_in) begin
            if (capture) begin
                word_q <= merged;
            end else if (count == 3'd0) begin
                // upper bytes read as zero on a new access
                word_q <= '0;
            end
        end
    end

endmodule

//--- logic/mem_ctrl_fsm.sv
`timescale 1ns/1ns

module mem_ctrl_fsm (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  rdy_in,
    input  logic                  io_full,
    input  logic                  read_mem,
    input  logic                  write_mem,
    input  logic [31:0]           mem_addr,
    input  logic [31:0]           mem_wdata,
    input  mem_pkg::access_size_e mem_size,
    input  logic                  if_read,
    input  logic [31:0]           if_addr,
    output logic                  cnt_start,
    output logic                  cnt_step,
    input  logic                  cnt_last,
    input  logic [2:0]            count,
    output logic                  lane_capture,
    input  logic [31:0]           lane_word,
    cache_port_if.fsm             icache,
    cache_port_if.fsm             dcache,
    output logic                  mem_done,
    output logic [31:0]           mem_rdata,
    output logic                  if_done,
    output logic [31:0]           if_instr,
    output logic [1:0]            busy,
    output logic                  ram_wr,
    output logic [31:0]           ram_addr
);

    mem_pkg::ctrl_state_e state;
    logic        tail_q;
    logic        console;
    logic        dcache_ok;
    logic        fetch_last;
    logic        store_end;
    logic        dhit_take;
    logic        ihit_take;
    logic [31:0] base_addr;

    assign console    = mem_pkg::is_console(mem_addr);
    assign dcache_ok  = (mem_size == mem_pkg::SIZE_WORD) && !console;
    assign fetch_last = (count == 3'd3);
    assign store_end  = (state == mem_pkg::DWRITE) && cnt_last;

    // priority is write, read, fetch
    assign dhit_take = (state == mem_pkg::IDLE) && !write_mem && read_mem
                       && dcache_ok && dcache.hit;
    assign ihit_take = (state == mem_pkg::IDLE) && !write_mem && !read_mem
                       && if_read && icache.hit;

    assign busy[0] = (state == mem_pkg::DREAD) || (state == mem_pkg::DWRITE)
                     || (state == mem_pkg::IOWAIT);
    assign busy[1] = (state == mem_pkg::FETCH);

    assign ram_wr    = (state == mem_pkg::DWRITE) && rdy_in;
    assign base_addr = (state == mem_pkg::FETCH) ? if_addr : mem_addr;
    // a frozen cycle re-reads the previous byte to keep ram_d_in in step with count
    assign ram_addr  = base_addr + {29'd0, count} - {31'd0, ~rdy_in};

    assign cnt_start    = (state == mem_pkg::IDLE);
    assign cnt_step     = (state == mem_pkg::DWRITE)
                          || (((state == mem_pkg::DREAD) || (state == mem_pkg::FETCH))
                              && !tail_q);
    assign lane_capture = ((state == mem_pkg::DREAD) || (state == mem_pkg::FETCH))
                          && (count != 3'd0);

    // write-through data cache
    assign dcache.lookup_addr = mem_addr[31:2];
    assign dcache.fill_en     = dcache_ok
                                && (((state == mem_pkg::DREAD) && tail_q) || store_end);
    assign dcache.fill_data   = (state == mem_pkg::DWRITE) ? mem_wdata : lane_word;
    assign dcache.inval_en    = store_end && !console
                                && (mem_size != mem_pkg::SIZE_WORD) && dcache.hit;

    assign icache.lookup_addr = if_addr[31:2];
    assign icache.fill_en     = (state == mem_pkg::FETCH) && tail_q;
    assign icache.fill_data   = lane_word;
    assign icache.inval_en    = 1'b0;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state    <= mem_pkg::IDLE;
            tail_q   <= 1'b0;
            mem_done <= 1'b0;
            if_done  <= 1'b0;
        end else if (rdy_in) begin
            mem_done <= 1'b0;
            if_done  <= 1'b0;
            case (state)
                mem_pkg::IDLE: begin
                    tail_q <= 1'b0;
                    if (write_mem) begin
                        state <= console ? mem_pkg::IOWAIT : mem_pkg::DWRITE;
                    end else if (read_mem) begin
                        if (dhit_take) begin
                            mem_done <= 1'b1;
                            state    <= mem_pkg::DONE;
                        end else begin
                            state <= mem_pkg::DREAD;
                        end
                    end else if (if_read) begin
                        if (ihit_take) begin
                            if_done <= 1'b1;
                            state   <= mem_pkg::DONE;
                        end else begin
                            state <= mem_pkg::FETCH;
                        end
                    end
                end
                mem_pkg::DREAD: begin
                    // one extra cycle to capture the final byte
                    if (tail_q) begin
                        mem_done <= 1'b1;
                        state    <= mem_pkg::DONE;
                    end else if (cnt_last) begin
                        tail_q <= 1'b1;
                    end
                end
                mem_pkg::DWRITE: begin
                    if (cnt_last) begin
                        mem_done <= 1'b1;
                        state    <= mem_pkg::DONE;
                    end
                end
                mem_pkg::IOWAIT: begin
                    if (!io_full) begin
                        state <= mem_pkg::DWRITE;
                    end
                end
                mem_pkg::FETCH: begin
                    if (tail_q) begin
                        if_done <= 1'b1;
                        state   <= mem_pkg::DONE;
                    end else if (fetch_last) begin
                        tail_q <= 1'b1;
                    end
                end
                mem_pkg::DONE: begin
                    state <= mem_pkg::IDLE;
                end
                default: begin
                    state <= mem_pkg::IDLE;
                end
            endcase
        end
    end

    // results hold until the next done
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (dhit_take) begin
                mem_rdata <= dcache.rdata;
            end else if ((state == mem_pkg::DREAD) && tail_q) begin
                mem_rdata <= lane_word;
            end
            if (ihit_take) begin
                if_instr <= icache.rdata;
            end else if ((state == mem_pkg::FETCH) && tail_q) begin
                if_instr <= lane_word;
            end
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in) !(mem_done && if_done));

    // console store stays off the RAM while the console is full
    assert property (@(posedge clk_in) disable iff (rst_in)
        (state == mem_pkg::IOWAIT) |-> !ram_wr);

endmodule

//--- logic/mem_ctrl_top.sv
`timescale 1ns/1ns

module mem_ctrl_top #(
    parameter int ICACHE_INDEX_LEN = 7,
    parameter int DCACHE_INDEX_LEN = 6
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  rdy_in,
    input  logic                  io_full,
    input  logic                  read_mem,
    input  logic                  write_mem,
    input  logic [31:0]           mem_addr,
    input  logic [31:0]           mem_wdata,
    input  mem_pkg::access_size_e mem_size,
    input  logic                  if_read,
    input  logic [31:0]           if_addr,
    output logic                  mem_done,
    output logic [31:0]           mem_rdata,
    output logic                  if_done,
    output logic [31:0]           if_instr,
    output logic [1:0]            busy,
    input  logic [7:0]            ram_d_in,
    output logic                  ram_wr,
    output logic [31:0]           ram_addr,
    output logic [7:0]            ram_d_out
);

    logic        cnt_start;
    logic        cnt_step;
    logic        cnt_last;
    logic [2:0]  count;
    logic        lane_capture;
    logic [31:0] lane_word;

    cache_port_if #(.INDEX_LEN(ICACHE_INDEX_LEN)) icache_port ();
    cache_port_if #(.INDEX_LEN(DCACHE_INDEX_LEN)) dcache_port ();

    mem_ctrl_fsm u_fsm (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .rdy_in       (rdy_in),
        .io_full      (io_full),
        .read_mem     (read_mem),
        .write_mem    (write_mem),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_size     (mem_size),
        .if_read      (if_read),
        .if_addr      (if_addr),
        .cnt_start    (cnt_start),
        .cnt_step     (cnt_step),
        .cnt_last     (cnt_last),
        .count        (count),
        .lane_capture (lane_capture),
        .lane_word    (lane_word),
        .icache       (icache_port),
        .dcache       (dcache_port),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata),
        .if_done      (if_done),
        .if_instr     (if_instr),
        .busy         (busy),
        .ram_wr       (ram_wr),
        .ram_addr     (ram_addr)
    );

    byte_counter u_counter (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .rdy_in (rdy_in),
        .start  (cnt_start),
        .step   (cnt_step),
        .size   (mem_size),
        .count  (count),
        .last   (cnt_last)
    );

    byte_lanes u_lanes (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .rdy_in   (rdy_in),
        .capture  (lane_capture),
        .count    (count),
        .ram_d_in (ram_d_in),
        .wdata    (mem_wdata),
        .word_out (lane_word),
        .byte_out (ram_d_out)
    );

    direct_cache #(.INDEX_LEN(ICACHE_INDEX_LEN)) u_icache (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .rdy_in (rdy_in),
        .cache  (icache_port)
    );

    direct_cache #(.INDEX_LEN(DCACHE_INDEX_LEN)) u_dcache (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .rdy_in (rdy_in),
        .cache  (dcache_port)
    );

endmodule

//--- bench/tb_mem_ctrl.sv
`timescale 1ns/1ns

module tb_mem_ctrl;

    logic                  clk_in;
    logic                  rst_in;
    logic                  rdy_in;
    logic                  io_full;
    logic                  read_mem;
    logic                  write_mem;
    logic [31:0]           mem_addr;
    logic [31:0]           mem_wdata;
    mem_pkg::access_size_e mem_size;
    logic                  if_read;
    logic [31:0]           if_addr;
    logic                  mem_done;
    logic [31:0]           mem_rdata;
    logic                  if_done;
    logic [31:0]           if_instr;
    logic [1:0]            busy;
    logic [7:0]            ram_d_in;
    logic                  ram_wr;
    logic [31:0]           ram_addr;
    logic [7:0]            ram_d_out;

    // 256 KB covers data, fetch and console regions
    logic [7:0]  ram     [0:262143];
    logic [7:0]  ref_mem [0:262143];
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;

    mem_ctrl_top #(.ICACHE_INDEX_LEN(7), .DCACHE_INDEX_LEN(6)) dut (.*);

    always #20 clk_in = ~clk_in;

    // byte-wide RAM with read data one cycle behind the address
    always @(posedge clk_in) begin
        if (ram_wr) begin
            ram[ram_addr[17:0]] <= ram_d_out;
        end
        ram_d_in <= ram[ram_addr[17:0]];
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int byte_count(input mem_pkg::access_size_e size);
        if (size == mem_pkg::SIZE_WORD) return 4;
        if (size == mem_pkg::SIZE_HALF) return 2;
        return 1;
    endfunction

    // zero extended since the core does sign extension
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input mem_pkg::access_size_e size);
        logic [31:0] word;
        word = '0;
        for (int k = 0; k < byte_count(size); k++) begin
            word[8*k +: 8] = ref_mem[addr[17:0] + k];
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_done(input bit fetch, input string what,
                             output int cycles, output int writes);
        bit seen;
        cycles = 0;
        writes = 0;
        seen   = 1'b0;
        while (!seen && cycles < 50) begin
            @(negedge clk_in);
            cycles++;
            if (ram_wr) writes++;
            seen = fetch ? if_done : mem_done;
        end
        if (!seen) begin
            errors++;
            $display("timeout at %0t: no done pulse for the %s", $time, what);
        end
    endtask

    task automatic load_and_check(input logic [31:0] addr,
                                  input mem_pkg::access_size_e size,
                                  output int cycles, output int writes);
        @(negedge clk_in);
        read_mem = 1'b1;
        mem_addr = addr;
        mem_size = size;
        wait_done(1'b0, "load", cycles, writes);
        read_mem = 1'b0;
        check_value("mem_rdata", mem_rdata, expected_load(addr, size));
    endtask

    task automatic store_bytes(input logic [31:0] addr, input mem_pkg::access_size_e size,
                               input logic [31:0] data);
        int cycles;
        int writes;
        @(negedge clk_in);
        write_mem = 1'b1;
        mem_addr  = addr;
        mem_size  = size;
        mem_wdata = data;
        wait_done(1'b0, "store", cycles, writes);
        write_mem = 1'b0;
        for (int k = 0; k < byte_count(size); k++) begin
            ref_mem[addr[17:0] + k] = data[8*k +: 8];
        end
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, output int cycles);
        int writes;
        @(negedge clk_in);
        if_read = 1'b1;
        if_addr = addr;
        wait_done(1'b1, "fetch", cycles, writes);
        if_read = 1'b0;
        check_value("if_instr", if_instr, expected_load(addr, mem_pkg::SIZE_WORD));
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s done, %0d failed checks", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        logic [31:0]           v;
        logic [31:0]           data;
        logic [31:0]           addr;
        mem_pkg::access_size_e size;
        int                    cycles;
        int                    writes;
        clk_in = 1'b0;
        rst_in = 1'b1;
        rdy_in = 1'b1;
        io_full = 1'b0;
        read_mem = 1'b0;
        write_mem = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_size = mem_pkg::SIZE_BYTE;
        if_read = 1'b0;
        if_addr = '0;
        ram_d_in = '0;
        lfsr_state = 32'h97ef;
        errors = 0;
        checks = 0;
        tests = 0;
        err_mark = 0;
        for (int i = 0; i < 262144; i++) begin
            ram[i]     = i[7:0] ^ i[15:8] ^ {6'd0, i[17:16]} ^ 8'h5a;
            ref_mem[i] = i[7:0] ^ i[15:8] ^ {6'd0, i[17:16]} ^ 8'h5a;
        end
        repeat (8) @(negedge clk_in);
        rst_in = 1'b0;

        check_value("mem_done", mem_done, 0);
        check_value("if_done", if_done, 0);
        check_value("ram_wr", ram_wr, 0);
        check_value("busy", busy, 0);
        end_test("reset");

        for (int n = 0; n < 48; n++) begin
            take_bits(2, v);
            size = (v[1:0] == 2'd3) ? mem_pkg::SIZE_WORD : mem_pkg::access_size_e'(v[1:0]);
            take_bits(6, v);
            addr = 32'h1000 + {v[5:0], 2'b00};
            take_bits(2, v);
            if (size == mem_pkg::SIZE_HALF) addr = addr + {v[1], 1'b0};
            if (size == mem_pkg::SIZE_BYTE) addr = addr + v[1:0];
            take_bits(1, v);
            if (v[0]) begin
                take_bits(32, data);
                // cache the word first so the store has an entry to refresh or drop
                load_and_check({addr[31:2], 2'b00}, mem_pkg::SIZE_WORD, cycles, writes);
                store_bytes(addr, size, data);
                load_and_check({addr[31:2], 2'b00}, mem_pkg::SIZE_WORD, cycles, writes);
                // the reload hits after a word store and misses after a partial one
                check_value("reload cycles", cycles, (size == mem_pkg::SIZE_WORD) ? 1 : 6);
            end else begin
                load_and_check(addr, size, cycles, writes);
            end
        end
        end_test("random loads and stores");

        for (int n = 0; n < 4; n++) begin
            take_bits(6, v);
            addr = 32'h1000 + {v[5:0], 2'b00};
            load_and_check(addr, mem_pkg::SIZE_WORD, cycles, writes);
            load_and_check(addr, mem_pkg::SIZE_WORD, cycles, writes);
            check_value("load hit cycles", cycles, 1);
            check_value("ram_wr count", writes, 0);
        end
        end_test("data cache hit");

        for (int n = 0; n < 8; n++) begin
            take_bits(7, v);
            addr = 32'h8000 + {v[6:0], 2'b00};
            fetch_and_check(addr, cycles);
            fetch_and_check(addr, cycles);
            check_value("fetch hit cycles", cycles, 1);
        end
        end_test("fetch");

        take_bits(32, data);
        @(negedge clk_in);
        io_full   = 1'b1;
        write_mem = 1'b1;
        mem_addr  = mem_pkg::CONSOLE_ADDR0;
        mem_size  = mem_pkg::SIZE_BYTE;
        mem_wdata = data;
        repeat (10) begin
            @(negedge clk_in);
            check_value("ram_wr", ram_wr, 0);
            check_value("mem_done", mem_done, 0);
        end
        io_full = 1'b0;
        wait_done(1'b0, "console store", cycles, writes);
        write_mem = 1'b0;
        ref_mem[mem_pkg::CONSOLE_ADDR0[17:0]] = data[7:0];
        check_value("console byte", ram[mem_pkg::CONSOLE_ADDR0[17:0]], data[7:0]);
        end_test("console store");

        @(negedge clk_in);
        read_mem = 1'b1;
        mem_addr = 32'h2010;
        mem_size = mem_pkg::SIZE_WORD;
        repeat (2) @(negedge clk_in);
        check_value("busy", busy, 2'b01);
        rdy_in = 1'b0;
        repeat (6) begin
            @(negedge clk_in);
            check_value("busy", busy, 2'b01);
            check_value("mem_done", mem_done, 0);
        end
        rdy_in = 1'b1;
        wait_done(1'b0, "load after stall", cycles, writes);
        read_mem = 1'b0;
        check_value("mem_rdata", mem_rdata, expected_load(32'h2010, mem_pkg::SIZE_WORD));
        end_test("ready stall");

        $display("%0d tests, %0d checks, %0d failed", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- all.f
logic/mem_pkg.sv
logic/cache_port_if.sv
logic/direct_cache.sv
logic/byte_counter.sv
logic/byte_lanes.sv
logic/mem_ctrl_fsm.sv
logic/mem_ctrl_top.sv
bench/tb_mem_ctrl.sv
